//--- Makefile
# Verilator build and run for the multiplier testbench

VERILATOR ?= verilator
TOP       ?= multiplierTb
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SRCS := $(shell grep -v '^+' $(FILELIST)) multiplier_defs.svh
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q '^RESULT: PASS$$' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- addSubUnit.sv
// Sign-extended add or subtract of S with A, one bit wider than the operands.
// X takes the sign of the sum on every add or subtract.
// X is left alone during shifts, so it feeds back into A as a sign bit.

`timescale 1ns/1ps

`include "multiplier_defs.svh"

module addSubUnit (
    input  logic                   Clk,
    input  logic                   arstN,
    input  logic [`MULT_WIDTH-1:0] s,
    input  logic [`MULT_WIDTH-1:0] a,
    input  multiplierPkg::ctrlCmd_t cmd,
    output logic [`MULT_WIDTH:0]   sum,
    output logic                   x
);

    import multiplierPkg::*;

    logic [`MULT_WIDTH:0] aExt;
    logic [`MULT_WIDTH:0] sExt;
    logic [`MULT_WIDTH:0] operand;

    assign aExt = {a[`MULT_WIDTH-1], a};
    assign sExt = {s[`MULT_WIDTH-1], s};

    // two's complement of S for the last step
    always_comb begin
        if (cmd.aluOp == opSub) begin
            operand = ~sExt + 1'b1;
        end else begin
            operand = sExt;
        end
    end

    assign sum = aExt + operand;

    // sign flip-flop
    always_ff @(posedge Clk or negedge arstN) begin
        if (!arstN) begin
            x <= 1'b0;
        end else if (cmd.clearA) begin
            x <= 1'b0;
        end else if (cmd.aluOp != opNone) begin
            x <= sum[`MULT_WIDTH];
        end
    end

endmodule

//--- filelist.f
+incdir+.
multiplierPkg.sv
multControl.sv
shiftReg.sv
addSubUnit.sv
hexDriver.sv
multiplierTop.sv
multiplier_assert.sv
multiplierTb.sv

//--- hexDriver.sv
// Hex digit to seven-segment decoder.
// Outputs are active low, bit 0 is segment a and bit 6 is segment g.

`timescale 1ns/1ps

`include "multiplier_defs.svh"

module hexDriver (
    input  logic [3:0]            nibble,
    output logic [`SEG_WIDTH-1:0] seg
);

    always_comb begin
        case (nibble)
            4'h0: seg = 7'b1000000;
            4'h1: seg = 7'b1111001;
            4'h2: seg = 7'b0100100;
            4'h3: seg = 7'b0110000;
            4'h4: seg = 7'b0011001;
            4'h5: seg = 7'b0010010;
            4'h6: seg = 7'b0000010;
            4'h7: seg = 7'b1111000;
            4'h8: seg = 7'b0000000;
            4'h9: seg = 7'b0010000;
            // letters, b and d in lower case
            4'hA: seg = 7'b0001000;
            4'hB: seg = 7'b0000011;
            4'hC: seg = 7'b1000110;
            4'hD: seg = 7'b0100001;
            4'hE: seg = 7'b0000110;
            default: seg = 7'b0001110;
        endcase
    end

endmodule

//--- multControl.sv
// Control FSM for the signed add-shift multiplier.
// run and clearALoadB are plain levels sampled on Clk, with no synchroniser.
// A run takes 17 edges after the edge that samples run in idle.
// The machine waits in done until run has been low for one edge.

`timescale 1ns/1ps

`include "multiplier_defs.svh"

module multControl (
    input  logic                  Clk,
    input  logic                  arstN,
    input  logic                  run,
    input  logic                  clearALoadB,
    input  logic                  m,
    output multiplierPkg::ctrlCmd_t cmd
);

    import multiplierPkg::*;

    localparam int idxWidth = $clog2(`MULT_WIDTH);
    localparam logic [idxWidth-1:0] lastBit = idxWidth'(`MULT_WIDTH - 1);

    ctrlState_e            state;
    ctrlState_e            nextState;
    logic [idxWidth-1:0]   bitIdx;

    // state register
    always_ff @(posedge Clk or negedge arstN) begin
        if (!arstN) begin
            state <= idle;
        end else begin
            state <= nextState;
        end
    end

    // bit counter, restarted with every run
    always_ff @(posedge Clk or negedge arstN) begin
        if (!arstN) begin
            bitIdx <= '0;
        end else if (state == clearStart) begin
            bitIdx <= '0;
        end else if (state == shiftStep) begin
            bitIdx <= bitIdx + 1'b1;
        end
    end

    // next state
    always_comb begin
        nextState = state;
        case (state)
            idle: begin
                if (run) begin
                    nextState = clearStart;
                end
            end
            clearStart: begin
                nextState = addStep;
            end
            addStep: begin
                nextState = shiftStep;
            end
            shiftStep: begin
                if (bitIdx == lastBit) begin
                    nextState = done;
                end else begin
                    nextState = addStep;
                end
            end
            done: begin
                // hold the product until run drops
                if (!run) begin
                    nextState = idle;
                end
            end
            default: begin
                nextState = idle;
            end
        endcase
    end

    // command word
    always_comb begin
        cmd.clearA = 1'b0;
        cmd.loadB  = 1'b0;
        cmd.loadA  = 1'b0;
        cmd.aluOp  = opNone;
        cmd.shift  = 1'b0;
        case (state)
            idle: begin
                // loading B also clears A and X
                cmd.clearA = clearALoadB;
                cmd.loadB  = clearALoadB;
            end
            clearStart: begin
                cmd.clearA = 1'b1;
            end
            addStep: begin
                if (m) begin
                    cmd.loadA = 1'b1;
                    // sign bit of the multiplier has negative weight
                    if (bitIdx == lastBit) begin
                        cmd.aluOp = opSub;
                    end else begin
                        cmd.aluOp = opAdd;
                    end
                end
            end
            shiftStep: begin
                cmd.shift = 1'b1;
            end
            default: begin
                cmd.shift = 1'b0;
            end
        endcase
    end

endmodule

//--- multiplierPkg.sv
// Shared types for the multiplier control and datapath.
// The control unit produces one command word per cycle.
// Each datapath block decodes only the fields it needs.

package multiplierPkg;

    // control sequence, two states per multiplier bit
    typedef enum logic [2:0] {
        idle       = 3'd0,
        clearStart = 3'd1,
        addStep    = 3'd2,
        shiftStep  = 3'd3,
        done       = 3'd4
    } ctrlState_e;

    // adder operation on A and S
    typedef enum logic [1:0] {
        opNone = 2'b00,
        opAdd  = 2'b01,
        opSub  = 2'b10
    } aluOp_e;

    // command word to the datapath
    typedef struct packed {
        logic   clearA;
        logic   loadB;
        logic   loadA;
        aluOp_e aluOp;
        logic   shift;
    } ctrlCmd_t;

endpackage

//--- multiplierTb.sv
// Directed testbench for the 8-bit signed add-shift multiplier.
// Inputs change 1 ns after the rising edge, outputs are checked at the same point.
// A run is checked 17 edges after the edge that samples run, when the product is valid.
// Random operands come from a 16-bit Galois LFSR.

`timescale 1ns/1ps

`include "multiplier_defs.svh"

module multiplierTb;

    // about 40 runs of about 25 cycles, with a margin of four
    localparam int runCycles  = 25;
    localparam int runBudget  = 40;
    localparam int cycleLimit = runCycles * runBudget * 4;

    localparam logic [15:0] lfsrSeed = 16'd59786;
    localparam logic [15:0] lfsrTaps = 16'hB400;

    logic                   Clk = 1'b0;
    logic                   arstN;
    logic                   run;
    logic                   clearALoadB;
    logic [`MULT_WIDTH-1:0] s;
    logic [`SEG_WIDTH-1:0]  aHexU;
    logic [`SEG_WIDTH-1:0]  aHexL;
    logic [`SEG_WIDTH-1:0]  bHexU;
    logic [`SEG_WIDTH-1:0]  bHexL;
    logic [`MULT_WIDTH-1:0] aVal;
    logic [`MULT_WIDTH-1:0] bVal;
    logic                   x;

    int          cycleCount = 0;
    int          errorCount = 0;
    int          checkCount = 0;
    int          testCount = 0;
    int          failedTests = 0;
    int          testErrors = 0;
    string       testName = "";
    logic [15:0] lfsrState;

    multiplierTop DUT (
        .Clk         (Clk),
        .arstN       (arstN),
        .run         (run),
        .clearALoadB (clearALoadB),
        .s           (s),
        .aHexU       (aHexU),
        .aHexL       (aHexL),
        .bHexU       (bHexU),
        .bHexL       (bHexL),
        .aVal        (aVal),
        .bVal        (bVal),
        .x           (x)
    );

    bind multControl multiplier_assert controlChecks (
        .Clk    (Clk),
        .arstN  (arstN),
        .state  (state),
        .bitIdx (bitIdx),
        .cmd    (cmd)
    );

    always #4 Clk = ~Clk;

    always @(posedge Clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= cycleLimit) begin
            $display("timeout: tests did not finish within %0d cycles", cycleLimit);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    function automatic logic [15:0] lfsrNext(input logic [15:0] cur);
        if (cur[0]) begin
            return (cur >> 1) ^ lfsrTaps;
        end
        return cur >> 1;
    endfunction

    // one LFSR step per bit taken
    function automatic logic [7:0] randomByte();
        logic [7:0] val;
        val = '0;
        for (int i = 0; i < 8; i++) begin
            val = {val[6:0], lfsrState[0]};
            lfsrState = lfsrNext(lfsrState);
        end
        return val;
    endfunction

    // active low, bit 0 is segment a
    function automatic logic [6:0] segFor(input logic [3:0] digit);
        case (digit)
            4'h0: return 7'b1000000;
            4'h1: return 7'b1111001;
            4'h2: return 7'b0100100;
            4'h3: return 7'b0110000;
            4'h4: return 7'b0011001;
            4'h5: return 7'b0010010;
            4'h6: return 7'b0000010;
            4'h7: return 7'b1111000;
            4'h8: return 7'b0000000;
            4'h9: return 7'b0010000;
            4'hA: return 7'b0001000;
            4'hB: return 7'b0000011;
            4'hC: return 7'b1000110;
            4'hD: return 7'b0100001;
            4'hE: return 7'b0000110;
            default: return 7'b0001110;
        endcase
    endfunction

    function automatic logic [15:0] signedProduct(input logic [7:0] sv, input logic [7:0] bv);
        logic signed [15:0] sWide;
        logic signed [15:0] bWide;
        sWide = {{8{sv[7]}}, sv};
        bWide = {{8{bv[7]}}, bv};
        return sWide * bWide;
    endfunction

    task automatic waitEdges(input int n);
        repeat (n) @(posedge Clk);
        #1;
    endtask

    task automatic checkValue(input string what, input logic [15:0] expected,
                              input logic [15:0] actual);
        checkCount++;
        if (expected !== actual) begin
            $display("Mismatch in %s: %s expected 0x%0h actual 0x%0h",
                     testName, what, expected, actual);
            errorCount++;
            testErrors++;
        end
    endtask

    task automatic checkDisplay(input logic [7:0] expA, input logic [7:0] expB);
        checkValue("aHexU", {9'd0, segFor(expA[7:4])}, {9'd0, aHexU});
        checkValue("aHexL", {9'd0, segFor(expA[3:0])}, {9'd0, aHexL});
        checkValue("bHexU", {9'd0, segFor(expB[7:4])}, {9'd0, bHexU});
        checkValue("bHexL", {9'd0, segFor(expB[3:0])}, {9'd0, bHexL});
    endtask

    // x only carries the sign once a nonzero partial has been added
    task automatic checkResult(input logic [15:0] expected);
        checkValue("aVal", {8'd0, expected[15:8]}, {8'd0, aVal});
        checkValue("bVal", {8'd0, expected[7:0]}, {8'd0, bVal});
        if (expected != 16'd0) begin
            checkValue("x", {15'd0, expected[15]}, {15'd0, x});
        end
        checkDisplay(expected[15:8], expected[7:0]);
    endtask

    task automatic beginTest(input string name);
        testName = name;
        testErrors = 0;
        testCount++;
    endtask

    task automatic endTest();
        if (testErrors == 0) begin
            $display("%s: passed", testName);
        end else begin
            $display("%s: failed with %0d errors", testName, testErrors);
            failedTests++;
        end
    endtask

    task automatic loadB(input logic [7:0] value);
        s = value;
        clearALoadB = 1'b1;
        waitEdges(1);
        clearALoadB = 1'b0;
    endtask

    // load B, run, check 17 edges after run is sampled, release run
    task automatic multiplyOnce(input logic [7:0] sv, input logic [7:0] bv);
        loadB(bv);
        s = sv;
        run = 1'b1;
        waitEdges(18);
        checkResult(signedProduct(sv, bv));
        run = 1'b0;
        waitEdges(1);
    endtask

    task automatic testReset();
        beginTest("reset");
        checkResult(16'd0);
        checkValue("x", 16'd0, {15'd0, x});
        endTest();
    endtask

    task automatic testLoadB();
        beginTest("loadB");
        loadB(8'hA7);
        checkValue("bVal", 16'h00A7, {8'd0, bVal});
        checkValue("aVal", 16'd0, {8'd0, aVal});
        checkValue("x", 16'd0, {15'd0, x});
        checkDisplay(8'h00, 8'hA7);
        endTest();
    endtask

    task automatic testDirected();
        beginTest("directed");
        multiplyOnce(8'd7, 8'd3);
        multiplyOnce(8'hFF, 8'hFF);
        multiplyOnce(8'h80, 8'h80);
        multiplyOnce(8'h80, 8'h7F);
        multiplyOnce(8'h00, 8'hFB);
        multiplyOnce(8'h05, 8'hFF);
        endTest();
    endtask

    task automatic testRandom();
        logic [7:0] sv;
        logic [7:0] bv;
        beginTest("random");
        for (int i = 0; i < 20; i++) begin
            sv = randomByte();
            bv = randomByte();
            multiplyOnce(sv, bv);
        end
        endTest();
    endtask

    task automatic testChained();
        logic [15:0] first;
        beginTest("chained");
        multiplyOnce(8'h9C, 8'h5D);
        first = signedProduct(8'h9C, 8'h5D);
        s = 8'h13;
        run = 1'b1;
        // A and X cleared one edge after the start
        waitEdges(2);
        checkValue("aVal at start", 16'd0, {8'd0, aVal});
        checkValue("x at start", 16'd0, {15'd0, x});
        waitEdges(16);
        checkResult(signedProduct(8'h13, first[7:0]));
        run = 1'b0;
        waitEdges(1);
        // a load in idle also clears A and X left by the run
        loadB(8'h42);
        checkValue("bVal after load", 16'h0042, {8'd0, bVal});
        checkValue("aVal after load", 16'd0, {8'd0, aVal});
        checkValue("x after load", 16'd0, {15'd0, x});
        endTest();
    endtask

    task automatic testRunHeld();
        logic [15:0] held;
        beginTest("runHeld");
        loadB(8'h36);
        s = 8'hE5;
        run = 1'b1;
        waitEdges(18);
        held = signedProduct(8'hE5, 8'h36);
        checkResult(held);
        for (int i = 0; i < 10; i++) begin
            waitEdges(1);
            checkResult(held);
        end
        // load request while done
        s = 8'h11;
        clearALoadB = 1'b1;
        waitEdges(2);
        checkResult(held);
        clearALoadB = 1'b0;
        waitEdges(1);
        run = 1'b0;
        waitEdges(1);
        checkResult(held);
        s = 8'h07;
        run = 1'b1;
        waitEdges(18);
        checkResult(signedProduct(8'h07, held[7:0]));
        run = 1'b0;
        waitEdges(1);
        endTest();
    endtask

    initial begin
        arstN = 1'b0;
        run = 1'b0;
        clearALoadB = 1'b0;
        s = '0;
        lfsrState = lfsrSeed;
        repeat (2) @(posedge Clk);
        #1;
        arstN = 1'b1;
        testReset();
        testLoadB();
        testDirected();
        testRandom();
        testChained();
        testRunHeld();
        if (DUT.controlUnit.controlChecks.failCount != 0) begin
            $display("control assertions failed %0d times",
                     DUT.controlUnit.controlChecks.failCount);
            errorCount += DUT.controlUnit.controlChecks.failCount;
        end
        $display("tests: %0d, failed: %0d, checks: %0d, errors: %0d",
                 testCount, failedTests, checkCount, errorCount);
        if (errorCount == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- multiplierTop.sv
// Top level of the 8-bit signed add-shift multiplier.
// The 16-bit product ends in A:B, high byte in aVal, low byte in bVal.
// Board inputs are used as they come, no debouncing or synchronising.
// A new run multiplies the current bVal by s.

`timescale 1ns/1ps

`include "multiplier_defs.svh"

module multiplierTop (
    input  logic                   Clk,
    input  logic                   arstN,
    input  logic                   run,
    input  logic                   clearALoadB,
    input  logic [`MULT_WIDTH-1:0] s,
    output logic [`SEG_WIDTH-1:0]  aHexU,
    output logic [`SEG_WIDTH-1:0]  aHexL,
    output logic [`SEG_WIDTH-1:0]  bHexU,
    output logic [`SEG_WIDTH-1:0]  bHexL,
    output logic [`MULT_WIDTH-1:0] aVal,
    output logic [`MULT_WIDTH-1:0] bVal,
    output logic                   x
);

    import multiplierPkg::*;

    ctrlCmd_t             cmd;
    logic [`MULT_WIDTH:0] sum;
    logic                 aShiftOut;
    // current multiplier bit, B bit 0
    logic                 m;

    multControl controlUnit (
        .Clk         (Clk),
        .arstN       (arstN),
        .run         (run),
        .clearALoadB (clearALoadB),
        .m           (m),
        .cmd         (cmd)
    );

    // high byte, shifts in the sign from X
    shiftReg regA (
        .Clk      (Clk),
        .arstN    (arstN),
        .clear    (cmd.clearA),
        .load     (cmd.loadA),
        .shiftEn  (cmd.shift),
        .shiftIn  (x),
        .d        (sum[`MULT_WIDTH-1:0]),
        .shiftOut (aShiftOut),
        .q        (aVal)
    );

    // multiplier, then low byte of the product
    shiftReg regB (
        .Clk      (Clk),
        .arstN    (arstN),
        .clear    (1'b0),
        .load     (cmd.loadB),
        .shiftEn  (cmd.shift),
        .shiftIn  (aShiftOut),
        .d        (s),
        .shiftOut (m),
        .q        (bVal)
    );

    addSubUnit addUnit (
        .Clk   (Clk),
        .arstN (arstN),
        .s     (s),
        .a     (aVal),
        .cmd   (cmd),
        .sum   (sum),
        .x     (x)
    );

    hexDriver hexAU (.nibble(aVal[7:4]), .seg(aHexU));
    hexDriver hexAL (.nibble(aVal[3:0]), .seg(aHexL));
    hexDriver hexBU (.nibble(bVal[7:4]), .seg(bHexU));
    hexDriver hexBL (.nibble(bVal[3:0]), .seg(bHexL));

endmodule

//--- multiplier_assert.sv
// Concurrent checks on the command word of the multiplier control FSM.
// Bound into multControl, so it sees the state and the bit index directly.
// Needs assertions enabled in the simulator.

`timescale 1ns/1ps

`include "multiplier_defs.svh"

module multiplier_assert (
    input logic                           Clk,
    input logic                           arstN,
    input multiplierPkg::ctrlState_e      state,
    input logic [$clog2(`MULT_WIDTH)-1:0] bitIdx,
    input multiplierPkg::ctrlCmd_t        cmd
);

    import multiplierPkg::*;

    localparam int lastBit = `MULT_WIDTH - 1;

    // number of failed assertions
    int failCount = 0;

    // A takes either the sum or the shift, never both
    loadNotShift: assert property (@(posedge Clk) disable iff (!arstN)
        !(cmd.loadA && cmd.shift))
        else begin
            $error("loadA and shift active in the same cycle");
            failCount++;
        end

    loadBInIdle: assert property (@(posedge Clk) disable iff (!arstN)
        cmd.loadB |-> (state == idle))
        else begin
            $error("loadB active outside idle");
            failCount++;
        end

    // subtract belongs to the sign bit of the multiplier
    subOnLastBit: assert property (@(posedge Clk) disable iff (!arstN)
        (cmd.aluOp == opSub) |-> (state == addStep && bitIdx == lastBit))
        else begin
            $error("opSub issued on a bit other than the last");
            failCount++;
        end

    doneQuiet: assert property (@(posedge Clk) disable iff (!arstN)
        (state == done) |-> (cmd == '0))
        else begin
            $error("command field active in done");
            failCount++;
        end

endmodule

//--- multiplier_defs.svh
// Width constants for the signed add-shift multiplier.
// The datapath is written for 8-bit operands and a 9-bit adder.
// Other operand widths are not supported by the control or the display.

`ifndef MULTIPLIER_DEFS_SVH
`define MULTIPLIER_DEFS_SVH

// operand width of S, A and B
`define MULT_WIDTH 8

// one segment per bit, active low, bit 6 is segment g
`define SEG_WIDTH 7

`endif

//--- shiftReg.sv
// Register with synchronous clear, parallel load and right shift.
// Priority is clear, then load, then shift.
// shiftOut is bit 0, the bit that leaves on the next shift.

`timescale 1ns/1ps

`include "multiplier_defs.svh"

module shiftReg (
    input  logic                   Clk,
    input  logic                   arstN,
    input  logic                   clear,
    input  logic                   load,
    input  logic                   shiftEn,
    input  logic                   shiftIn,
    input  logic [`MULT_WIDTH-1:0] d,
    output logic                   shiftOut,
    output logic [`MULT_WIDTH-1:0] q
);

    always_ff @(posedge Clk or negedge arstN) begin
        if (!arstN) begin
            q <= '0;
        end else if (clear) begin
            q <= '0;
        end else if (load) begin
            q <= d;
        end else if (shiftEn) begin
            // new bit enters at the top
            q <= {shiftIn, q[`MULT_WIDTH-1:1]};
        end
    end

    assign shiftOut = q[0];

endmodule
